/* compile.f */
src/shop_rec_pkg.sv
src/shop_cmd_pkg.sv
src/cmd_capture.sv
src/record_port.sv
src/trade_calc.sv
src/shop_ctrl.sv
src/shop_top.sv
verif/tb_clock_gen.sv
verif/tb_record_mem.sv
verif/tb_shop_top.sv

/* src/cmd_capture.sv */
`timescale 1ns/1ps

module cmd_capture import shop_cmd_pkg::*; (
    input  logic        clk,
    input  logic        inf,
    input  logic        id_valid,
    input  logic        act_valid,
    input  logic        item_valid,
    input  logic        num_valid,
    input  logic        amnt_valid,
    input  logic [15:0] d,
    output command_t    cmd,
    output logic        cmd_ready
);

    logic [2:0] field_cnt;
    logic       any_field;
    logic       last_field;

    assign any_field = id_valid | act_valid | item_valid | num_valid | amnt_valid;

    // check ends at its action, deposit at the amount, buy at the seller id.
    assign last_field = (act_valid && d[3:0] == act_check) || amnt_valid ||
                        (id_valid && field_cnt != 3'd0);

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            field_cnt <= 3'd0;
            cmd_ready <= 1'b0;
        end else begin
            cmd_ready <= last_field;
            if (last_field) begin
                field_cnt <= 3'd0;
            end else if (any_field) begin
                field_cnt <= field_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid && field_cnt == 3'd0) begin
            cmd.buyer_id <= d[7:0];
        end
        if (id_valid && field_cnt != 3'd0) begin
            cmd.seller_id <= d[7:0];
        end
        if (act_valid) begin
            cmd.action <= action_t'(d[3:0]);
        end
        if (item_valid) begin
            cmd.item_id <= d[1:0];
        end
        if (num_valid) begin
            cmd.item_num <= d[5:0];
        end
        if (amnt_valid) begin
            cmd.amount <= d;
        end
    end

endmodule

/* src/record_port.sv */
`timescale 1ns/1ps

module record_port import shop_rec_pkg::*; #(
    parameter logic [16:0] rec_base = 17'h10000
) (
    input  logic        clk,
    input  logic        inf,
    input  logic        rd_req,
    input  logic        wr_req,
    input  user_id_t    uid,
    input  record_t     wr_rec,
    output record_t     rd_rec,
    output logic        rsp_done,
    output logic [16:0] c_addr,
    output logic [63:0] c_data_w,
    output logic        c_r_wb,
    output logic        c_in_valid,
    input  logic        c_out_valid,
    input  logic [63:0] c_data_r
);

    // memory keeps each 32-bit half in reversed byte order.
    function automatic logic [63:0] swap_halves(input logic [63:0] w);
        return {w[39:32], w[47:40], w[55:48], w[63:56],
                w[7:0],   w[15:8],  w[23:16], w[31:24]};
    endfunction

    logic [16:0] rec_addr;

    // eight bytes per user record.
    assign rec_addr = rec_base + {6'd0, uid, 3'd0};

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            c_in_valid <= 1'b0;
            c_r_wb     <= 1'b0;
        end else begin
            c_in_valid <= rd_req | wr_req;
            if (rd_req || wr_req) begin
                c_r_wb <= rd_req;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req || wr_req) begin
            c_addr <= rec_addr;
        end
        if (wr_req) begin
            c_data_w <= swap_halves(wr_rec);
        end
    end

    // read word is taken by the controller in the acknowledge cycle.
    assign rd_rec   = record_t'(swap_halves(c_data_r));
    assign rsp_done = c_out_valid;

endmodule

/* src/shop_cmd_pkg.sv */
package shop_cmd_pkg;
    import shop_rec_pkg::*;

    typedef enum logic [3:0] {
        act_buy     = 4'd1,
        act_check   = 4'd2,
        act_deposit = 4'd4
    } action_t;

    typedef enum logic [3:0] {
        err_none         = 4'b0000,
        err_seller_short = 4'b0010,
        err_no_money     = 4'b0011,
        err_buyer_full   = 4'b0100,
        err_wallet_full  = 4'b1000
    } err_t;

    typedef struct packed {
        action_t   action;
        user_id_t  buyer_id;
        user_id_t  seller_id;
        item_id_t  item_id;
        item_num_t item_num;
        money_t    amount;
    } command_t;

    typedef struct packed {
        logic        complete;
        err_t        err;
        logic [31:0] info;
    } response_t;

endpackage

/* src/shop_ctrl.sv */
`timescale 1ns/1ps

module shop_ctrl import shop_rec_pkg::*, shop_cmd_pkg::*; (
    input  logic      clk,
    input  logic      inf,
    input  command_t  cmd,
    input  logic      cmd_ready,
    input  record_t   rd_rec,
    input  logic      rsp_done,
    input  record_t   new_buyer,
    input  record_t   new_seller,
    input  err_t      err,
    output logic      rd_req,
    output logic      wr_req,
    output user_id_t  uid,
    output record_t   wr_rec,
    output record_t   buyer,
    output record_t   seller,
    output response_t rsp,
    output logic      out_valid
);

    typedef enum logic [2:0] {
        st_idle,
        st_rd_buyer,
        st_rd_seller,
        st_calc,
        st_wr_buyer,
        st_wr_seller,
        st_resp
    } state_t;

    state_t state;
    logic   is_buy;
    logic   seller_slot;

    // info is only reported for a completed action.
    function automatic response_t make_rsp(input err_t e, input logic [31:0] info);
        response_t r;
        r.complete = (e == err_none);
        r.err      = e;
        r.info     = info;
        return r;
    endfunction

    assign is_buy      = (cmd.action == act_buy);
    assign seller_slot = (state == st_rd_buyer) || (state == st_wr_buyer);
    assign uid         = seller_slot ? cmd.seller_id : cmd.buyer_id;
    assign wr_rec      = (state == st_calc) ? new_buyer : seller;

    // each request goes out in the cycle of the event that allows it.
    always_comb begin
        rd_req = 1'b0;
        wr_req = 1'b0;
        case (state)
            st_idle:     rd_req = cmd_ready;
            st_rd_buyer: rd_req = rsp_done && is_buy;
            st_calc:     wr_req = (err == err_none);
            st_wr_buyer: wr_req = rsp_done && is_buy;
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state     <= st_idle;
            out_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            out_valid <= 1'b0;
            rsp       <= '0;
            case (state)
                st_idle: begin
                    if (cmd_ready) begin
                        state <= st_rd_buyer;
                    end
                end
                st_rd_buyer: begin
                    if (rsp_done && is_buy) begin
                        state <= st_rd_seller;
                    end else if (rsp_done && cmd.action == act_deposit) begin
                        state <= st_calc;
                    end else if (rsp_done) begin
                        state     <= st_resp;
                        out_valid <= 1'b1;
                        rsp       <= make_rsp(err_none, {16'd0, rd_rec.user.money});
                    end
                end
                st_rd_seller: begin
                    if (rsp_done) begin
                        state <= st_calc;
                    end
                end
                st_calc: begin
                    if (err != err_none) begin
                        state     <= st_resp;
                        out_valid <= 1'b1;
                        rsp       <= make_rsp(err, 32'd0);
                    end else begin
                        state <= st_wr_buyer;
                    end
                end
                st_wr_buyer: begin
                    if (rsp_done && is_buy) begin
                        state <= st_wr_seller;
                    end else if (rsp_done) begin
                        state     <= st_resp;
                        out_valid <= 1'b1;
                        rsp       <= make_rsp(err_none, {16'd0, buyer.user.money});
                    end
                end
                st_wr_seller: begin
                    if (rsp_done) begin
                        state     <= st_resp;
                        out_valid <= 1'b1;
                        rsp       <= make_rsp(err_none, buyer.user);
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // working copies of both records.
    always_ff @(posedge clk) begin
        if (rsp_done && state == st_rd_buyer) begin
            buyer <= rd_rec;
        end
        if (rsp_done && state == st_rd_seller) begin
            seller <= rd_rec;
        end
        if (state == st_calc) begin
            buyer  <= new_buyer;
            seller <= new_seller;
        end
    end

endmodule

/* src/shop_rec_pkg.sv */
package shop_rec_pkg;

    typedef logic [7:0]  user_id_t;
    typedef logic [1:0]  item_id_t;
    typedef logic [5:0]  item_num_t;
    typedef logic [15:0] money_t;

    localparam item_num_t item_max  = 6'd63;
    localparam money_t    money_max = 16'hffff;

    typedef struct packed {
        logic [5:0]  large_num;
        logic [5:0]  medium_num;
        logic [5:0]  small_num;
        logic [1:0]  level;
        logic [11:0] exp;
    } shop_info_t;

    typedef struct packed {
        item_id_t  item_id;
        item_num_t item_num;
        user_id_t  seller_id;
    } history_t;

    typedef struct packed {
        money_t   money;
        history_t history;
    } user_info_t;

    typedef struct packed {
        user_info_t user;
        shop_info_t shop;
    } record_t;

    function automatic logic [8:0] item_price(input item_id_t id);
        case (id)
            2'd1:    return 9'd300;
            2'd2:    return 9'd200;
            2'd3:    return 9'd100;
            default: return 9'd0;
        endcase
    endfunction

    // experience per unit.
    function automatic logic [5:0] item_exp(input item_id_t id);
        case (id)
            2'd1:    return 6'd60;
            2'd2:    return 6'd40;
            2'd3:    return 6'd20;
            default: return 6'd0;
        endcase
    endfunction

    function automatic logic [6:0] level_fee(input logic [1:0] level);
        case (level)
            2'd0:    return 7'd10;
            2'd1:    return 7'd30;
            2'd2:    return 7'd50;
            default: return 7'd70;
        endcase
    endfunction

    // level 0 is the top level and never upgrades.
    function automatic logic [11:0] level_threshold(input logic [1:0] level);
        case (level)
            2'd0:    return 12'd0;
            2'd1:    return 12'd4000;
            2'd2:    return 12'd2500;
            default: return 12'd1000;
        endcase
    endfunction

endpackage

/* src/shop_top.sv */
`timescale 1ns/1ps

module shop_top import shop_rec_pkg::*, shop_cmd_pkg::*; #(
    parameter logic [16:0] rec_base = 17'h10000
) (
    input  logic        clk,
    input  logic        inf,
    input  logic        id_valid,
    input  logic        act_valid,
    input  logic        item_valid,
    input  logic        num_valid,
    input  logic        amnt_valid,
    input  logic [15:0] d,
    output logic        out_valid,
    output logic        complete,
    output logic [3:0]  err_msg,
    output logic [31:0] out_info,
    output logic        c_in_valid,
    output logic        c_r_wb,
    output logic [16:0] c_addr,
    output logic [63:0] c_data_w,
    input  logic        c_out_valid,
    input  logic [63:0] c_data_r
);

    command_t  cmd;
    logic      cmd_ready;
    logic      rd_req;
    logic      wr_req;
    logic      rsp_done;
    user_id_t  uid;
    record_t   wr_rec;
    record_t   rd_rec;
    record_t   buyer;
    record_t   seller;
    record_t   new_buyer;
    record_t   new_seller;
    err_t      err;
    response_t rsp;

    cmd_capture u_capture (
        .clk        (clk),
        .inf        (inf),
        .id_valid   (id_valid),
        .act_valid  (act_valid),
        .item_valid (item_valid),
        .num_valid  (num_valid),
        .amnt_valid (amnt_valid),
        .d          (d),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready)
    );

    record_port #(
        .rec_base (rec_base)
    ) u_port (
        .clk         (clk),
        .inf         (inf),
        .rd_req      (rd_req),
        .wr_req      (wr_req),
        .uid         (uid),
        .wr_rec      (wr_rec),
        .rd_rec      (rd_rec),
        .rsp_done    (rsp_done),
        .c_addr      (c_addr),
        .c_data_w    (c_data_w),
        .c_r_wb      (c_r_wb),
        .c_in_valid  (c_in_valid),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r)
    );

    trade_calc u_calc (
        .cmd        (cmd),
        .buyer      (buyer),
        .seller     (seller),
        .new_buyer  (new_buyer),
        .new_seller (new_seller),
        .err        (err)
    );

    shop_ctrl u_ctrl (
        .clk        (clk),
        .inf        (inf),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .rd_rec     (rd_rec),
        .rsp_done   (rsp_done),
        .new_buyer  (new_buyer),
        .new_seller (new_seller),
        .err        (err),
        .rd_req     (rd_req),
        .wr_req     (wr_req),
        .uid        (uid),
        .wr_rec     (wr_rec),
        .buyer      (buyer),
        .seller     (seller),
        .rsp        (rsp),
        .out_valid  (out_valid)
    );

    assign complete = rsp.complete;
    assign err_msg  = rsp.err;
    assign out_info = rsp.info;

endmodule

/* src/trade_calc.sv */
`timescale 1ns/1ps

module trade_calc import shop_rec_pkg::*, shop_cmd_pkg::*; (
    input  command_t cmd,
    input  record_t  buyer,
    input  record_t  seller,
    output record_t  new_buyer,
    output record_t  new_seller,
    output err_t     err
);

    item_num_t   buyer_stock;
    item_num_t   seller_stock;
    item_num_t   seller_left;
    logic [6:0]  stock_sum;
    logic [14:0] goods;
    logic [16:0] cost;
    logic [12:0] exp_sum;
    logic [16:0] seller_sum;
    logic [16:0] wallet_sum;
    money_t      seller_money;

    always_comb begin
        case (cmd.item_id)
            2'd1: begin
                buyer_stock  = buyer.shop.large_num;
                seller_stock = seller.shop.large_num;
            end
            2'd2: begin
                buyer_stock  = buyer.shop.medium_num;
                seller_stock = seller.shop.medium_num;
            end
            2'd3: begin
                buyer_stock  = buyer.shop.small_num;
                seller_stock = seller.shop.small_num;
            end
            default: begin
                buyer_stock  = '0;
                seller_stock = '0;
            end
        endcase
    end

    assign stock_sum    = {1'b0, buyer_stock} + {1'b0, cmd.item_num};
    assign seller_left  = seller_stock - cmd.item_num;
    assign goods        = cmd.item_num * item_price(cmd.item_id);
    assign cost         = goods + level_fee(buyer.shop.level);
    assign exp_sum      = buyer.shop.exp + cmd.item_num * item_exp(cmd.item_id);
    assign seller_sum   = seller.user.money + goods;
    assign wallet_sum   = buyer.user.money + cmd.amount;
    assign seller_money = (seller_sum > {1'b0, money_max}) ? money_max : seller_sum[15:0];

    always_comb begin
        new_buyer  = buyer;
        new_seller = seller;
        err        = err_none;
        case (cmd.action)
            act_buy: begin
                if (stock_sum > {1'b0, item_max}) begin
                    err = err_buyer_full;
                end else if (seller_stock < cmd.item_num) begin
                    err = err_seller_short;
                end else if ({1'b0, buyer.user.money} < cost) begin
                    err = err_no_money;
                end else begin
                    new_buyer.user.money             = buyer.user.money - cost[15:0];
                    new_buyer.user.history.item_id   = cmd.item_id;
                    new_buyer.user.history.item_num  = cmd.item_num;
                    new_buyer.user.history.seller_id = cmd.seller_id;
                    new_seller.user.money            = seller_money;
                    case (cmd.item_id)
                        2'd1: begin
                            new_buyer.shop.large_num  = stock_sum[5:0];
                            new_seller.shop.large_num = seller_left;
                        end
                        2'd2: begin
                            new_buyer.shop.medium_num  = stock_sum[5:0];
                            new_seller.shop.medium_num = seller_left;
                        end
                        2'd3: begin
                            new_buyer.shop.small_num  = stock_sum[5:0];
                            new_seller.shop.small_num = seller_left;
                        end
                        default: begin
                        end
                    endcase
                    // level-up restarts experience from zero.
                    if (exp_sum >= {1'b0, level_threshold(buyer.shop.level)} &&
                        buyer.shop.level != 2'd0) begin
                        new_buyer.shop.exp   = '0;
                        new_buyer.shop.level = buyer.shop.level - 2'd1;
                    end else begin
                        new_buyer.shop.exp = exp_sum[11:0];
                    end
                end
            end
            act_deposit: begin
                if (wallet_sum > {1'b0, money_max}) begin
                    err = err_wallet_full;
                end else begin
                    new_buyer.user.money = wallet_sum[15:0];
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 50,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic inf
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // reset is released just after a rising edge.
    initial begin
        inf = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 inf = 1'b1;
    end

endmodule

/* verif/tb_record_mem.sv */
`timescale 1ns/1ps

module tb_record_mem import shop_rec_pkg::*; #(
    parameter logic [16:0] rec_base = 17'h10000
) (
    input  logic        clk,
    input  logic        c_in_valid,
    input  logic        c_r_wb,
    input  logic [16:0] c_addr,
    input  logic [63:0] c_data_w,
    output logic        c_out_valid,
    output logic [63:0] c_data_r,
    input  logic [3:0]  lat,
    input  logic        ld_en,
    input  user_id_t    ld_idx,
    input  logic [63:0] ld_word
);

    logic [63:0] words [0:255];
    logic [16:0] offset;
    user_id_t    idx;
    int          wait_cnt;

    initial begin
        c_out_valid = 1'b0;
        c_data_r    = '0;
        wait_cnt    = 0;
        idx         = '0;
    end

    // one eight-byte record per user id.
    assign offset = c_addr - rec_base;

    always @(posedge clk) begin
        if (ld_en) begin
            words[ld_idx] = ld_word;
        end
        #1;
        c_out_valid <= 1'b0;
        if (wait_cnt > 0) begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
                c_out_valid <= 1'b1;
                c_data_r    <= words[idx];
            end
        end else if (c_in_valid) begin
            idx      = offset[10:3];
            wait_cnt = lat;
            if (!c_r_wb) begin
                words[offset[10:3]] = c_data_w;
            end
        end
    end

endmodule

/* verif/tb_shop_top.sv */
`timescale 1ns/1ps

module tb_shop_top import shop_rec_pkg::*, shop_cmd_pkg::*; ();

    localparam logic [16:0] rec_base   = 17'h10000;
    localparam int          n_directed = 16;
    localparam int          n_random   = 40;
    localparam int          max_cycles = 60 * (n_directed + n_random);

    typedef struct packed {
        logic        complete;
        logic [3:0]  err;
        logic [31:0] info;
    } expect_t;

    typedef enum {fld_id, fld_act, fld_item, fld_num, fld_amnt} field_t;

    logic        clk;
    logic        inf;
    logic        id_valid;
    logic        act_valid;
    logic        item_valid;
    logic        num_valid;
    logic        amnt_valid;
    logic [15:0] d;
    logic        out_valid;
    logic        complete;
    logic [3:0]  err_msg;
    logic [31:0] out_info;
    logic        c_in_valid;
    logic        c_r_wb;
    logic [16:0] c_addr;
    logic [63:0] c_data_w;
    logic        c_out_valid;
    logic [63:0] c_data_r;
    logic [3:0]  lat;
    logic        ld_en;
    user_id_t    ld_idx;
    logic [63:0] ld_word;

    record_t     shadow [0:15];
    expect_t     exp_q [$];
    string       name_q [$];
    logic [31:0] seed;
    int          errors;
    int          cycles;

    tb_clock_gen u_clk (
        .clk (clk),
        .inf (inf)
    );

    shop_top #(
        .rec_base (rec_base)
    ) u_shop_top (
        .clk         (clk),
        .inf         (inf),
        .id_valid    (id_valid),
        .act_valid   (act_valid),
        .item_valid  (item_valid),
        .num_valid   (num_valid),
        .amnt_valid  (amnt_valid),
        .d           (d),
        .out_valid   (out_valid),
        .complete    (complete),
        .err_msg     (err_msg),
        .out_info    (out_info),
        .c_in_valid  (c_in_valid),
        .c_r_wb      (c_r_wb),
        .c_addr      (c_addr),
        .c_data_w    (c_data_w),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r)
    );

    tb_record_mem #(
        .rec_base (rec_base)
    ) u_mem (
        .clk         (clk),
        .c_in_valid  (c_in_valid),
        .c_r_wb      (c_r_wb),
        .c_addr      (c_addr),
        .c_data_w    (c_data_w),
        .c_out_valid (c_out_valid),
        .c_data_r    (c_data_r),
        .lat         (lat),
        .ld_en       (ld_en),
        .ld_idx      (ld_idx),
        .ld_word     (ld_word)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int draw(input int range);
        seed = lcg_next(seed);
        return int'(seed[30:16]) % range;
    endfunction

    // memory holds each 32-bit half with its bytes reversed.
    function automatic logic [63:0] to_mem_order(input logic [63:0] w);
        logic [63:0] m;
        for (int k = 0; k < 4; k++) begin
            m[8*k +: 8]      = w[8*(3-k) +: 8];
            m[32+8*k +: 8]   = w[32+8*(3-k) +: 8];
        end
        return m;
    endfunction

    function automatic int get_stock(input record_t r, input item_id_t item);
        case (item)
            2'd1:    return r.shop.large_num;
            2'd2:    return r.shop.medium_num;
            default: return r.shop.small_num;
        endcase
    endfunction

    function automatic void set_stock(inout record_t r, input item_id_t item, input int v);
        case (item)
            2'd1:    r.shop.large_num = v;
            2'd2:    r.shop.medium_num = v;
            default: r.shop.small_num = v;
        endcase
    endfunction

    // reference model that updates the record copies and returns the expected response.
    function automatic expect_t trade_ref(input command_t c, inout record_t b, inout record_t s);
        expect_t e;
        int      price;
        int      unit_exp;
        int      fee;
        int      thr;
        int      cost;
        int      exp_new;
        e        = '0;
        price    = (c.item_id == 2'd1) ? 300 : (c.item_id == 2'd2) ? 200 : 100;
        // experience per unit is a fifth of the price.
        unit_exp = price / 5;
        fee      = 10 + 20 * b.shop.level;
        case (b.shop.level)
            2'd0:    thr = 0;
            2'd1:    thr = 4000;
            2'd2:    thr = 2500;
            default: thr = 1000;
        endcase
        cost = c.item_num * price + fee;
        if (c.action == act_check) begin
            e.complete = 1'b1;
            e.info     = {16'd0, b.user.money};
        end else if (c.action == act_deposit) begin
            if (b.user.money + c.amount > 65535) begin
                e.err = 4'b1000;
            end else begin
                b.user.money = b.user.money + c.amount;
                e.complete   = 1'b1;
                e.info       = {16'd0, b.user.money};
            end
        end else if (get_stock(b, c.item_id) + c.item_num > 63) begin
            e.err = 4'b0100;
        end else if (get_stock(s, c.item_id) < c.item_num) begin
            e.err = 4'b0010;
        end else if (b.user.money < cost) begin
            e.err = 4'b0011;
        end else begin
            b.user.money = b.user.money - cost;
            set_stock(b, c.item_id, get_stock(b, c.item_id) + c.item_num);
            set_stock(s, c.item_id, get_stock(s, c.item_id) - c.item_num);
            if (s.user.money + c.item_num * price > 65535) begin
                s.user.money = 16'hffff;
            end else begin
                s.user.money = s.user.money + c.item_num * price;
            end
            exp_new = b.shop.exp + c.item_num * unit_exp;
            if (exp_new >= thr && b.shop.level != 2'd0) begin
                b.shop.exp   = '0;
                b.shop.level = b.shop.level - 2'd1;
            end else begin
                b.shop.exp = exp_new;
            end
            b.user.history.item_id   = c.item_id;
            b.user.history.item_num  = c.item_num;
            b.user.history.seller_id = c.seller_id;
            e.complete = 1'b1;
            e.info     = b.user;
        end
        return e;
    endfunction

    task automatic strobe(input field_t field, input logic [15:0] val);
        d          = val;
        id_valid   = (field == fld_id);
        act_valid  = (field == fld_act);
        item_valid = (field == fld_item);
        num_valid  = (field == fld_num);
        amnt_valid = (field == fld_amnt);
        @(posedge clk);
        #1;
        id_valid   = 1'b0;
        act_valid  = 1'b0;
        item_valid = 1'b0;
        num_valid  = 1'b0;
        amnt_valid = 1'b0;
    endtask

    task automatic wait_response();
        do begin
            @(posedge clk);
        end while (out_valid !== 1'b1);
        #1;
    endtask

    task automatic send_cmd(input string name, input action_t act, input user_id_t buyer,
                            input user_id_t seller, input item_id_t item, input item_num_t num,
                            input money_t amount);
        command_t c;
        record_t  rb;
        record_t  rs;
        expect_t  e;
        c.action    = act;
        c.buyer_id  = buyer;
        c.seller_id = seller;
        c.item_id   = item;
        c.item_num  = num;
        c.amount    = amount;
        rb = shadow[buyer];
        rs = shadow[seller];
        e  = trade_ref(c, rb, rs);
        exp_q.push_back(e);
        name_q.push_back(name);
        shadow[buyer] = rb;
        if (act == act_buy) begin
            shadow[seller] = rs;
        end
        strobe(fld_id, buyer);
        strobe(fld_act, act);
        if (act == act_buy) begin
            strobe(fld_item, item);
            strobe(fld_num, num);
            strobe(fld_id, seller);
        end else if (act == act_deposit) begin
            strobe(fld_amnt, amount);
        end
        wait_response();
    endtask

    task automatic fill_records();
        for (int i = 0; i < 16; i++) begin
            shadow[i].user.money      = draw(60000);
            shadow[i].user.history    = 16'(draw(65536));
            shadow[i].shop.large_num  = draw(64);
            shadow[i].shop.medium_num = draw(64);
            shadow[i].shop.small_num  = draw(64);
            shadow[i].shop.level      = draw(4);
            shadow[i].shop.exp        = draw(1000);
        end
        // 12 is a rich level 3 buyer, 13 a full seller close to the money limit.
        shadow[12].user.money = 16'd50000;
        shadow[12].shop       = {6'd0, 6'd0, 6'd0, 2'd3, 12'd0};
        shadow[13].user.money = 16'd65400;
        shadow[13].shop       = {6'd63, 6'd63, 6'd63, 2'd0, 12'd0};
        shadow[14].user.money = 16'd50;
        shadow[14].shop       = {6'd60, 6'd10, 6'd10, 2'd2, 12'd0};
        shadow[15].user.money = 16'd100;
        shadow[15].shop       = {6'd2, 6'd2, 6'd2, 2'd1, 12'd0};
    endtask

    task automatic load_memory();
        for (int i = 0; i < 16; i++) begin
            ld_en   = 1'b1;
            ld_idx  = i;
            ld_word = to_mem_order(shadow[i]);
            @(posedge clk);
            #1;
        end
        ld_en = 1'b0;
    endtask

    task automatic check_memory();
        for (int i = 0; i < 16; i++) begin
            assert (u_mem.words[i] === to_mem_order(shadow[i])) else begin
                errors++;
                $display("[ERROR] final_memory user %0d expected %h actual %h",
                         i, to_mem_order(shadow[i]), u_mem.words[i]);
            end
        end
    endtask

    task automatic report_and_stop();
        $display("checks failed: %0d, responses missing: %0d", errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // draw a fresh latency every cycle so each request sees its own value.
    always @(negedge clk) begin
        if (inf === 1'b1) begin
            lat <= draw(8) + 1;
        end
    end

    // each memory request has to fall on a record of the 16 test users.
    always @(posedge clk) begin
        if (c_in_valid === 1'b1) begin
            assert (c_addr >= rec_base && c_addr < rec_base + 17'd128 &&
                    c_addr[2:0] == 3'd0) else begin
                errors++;
                $display("memory request address %h lies outside the record area", c_addr);
            end
        end
    end

    always @(posedge clk) begin : compare
        expect_t e;
        string   name;
        if (out_valid === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("out_valid arrived while no command was outstanding");
            end
            if (exp_q.size() > 0) begin
                e    = exp_q.pop_front();
                name = name_q.pop_front();
                assert (complete === e.complete) else begin
                    errors++;
                    $display("[ERROR] %s complete expected %b actual %b",
                             name, e.complete, complete);
                end
                assert (err_msg === e.err) else begin
                    errors++;
                    $display("[ERROR] %s err_msg expected %b actual %b", name, e.err, err_msg);
                end
                assert (out_info === e.info) else begin
                    errors++;
                    $display("[ERROR] %s out_info expected %h actual %h",
                             name, e.info, out_info);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            errors++;
            $display("timeout, out_valid did not arrive within %0d cycles", max_cycles);
            report_and_stop();
        end
    end

    initial begin : main
        int b;
        int s;
        int pick;
        int item;
        int num;
        int amount;
        id_valid   = 1'b0;
        act_valid  = 1'b0;
        item_valid = 1'b0;
        num_valid  = 1'b0;
        amnt_valid = 1'b0;
        d          = '0;
        lat        = 4'd1;
        ld_en      = 1'b0;
        ld_idx     = '0;
        ld_word    = '0;
        errors     = 0;
        cycles     = 0;
        seed       = 32'd17371;
        fill_records();
        @(posedge inf);
        load_memory();

        send_cmd("check_read", act_check, 3, 3, 0, 0, 0);
        send_cmd("check_buyer", act_check, 12, 12, 0, 0, 0);
        send_cmd("buy_ok", act_buy, 12, 13, 1, 10, 0);
        send_cmd("seller_saturate", act_check, 13, 13, 0, 0, 0);
        send_cmd("buyer_after_buy", act_check, 12, 12, 0, 0, 0);
        send_cmd("buyer_full", act_buy, 14, 13, 1, 5, 0);
        send_cmd("seller_short", act_buy, 12, 15, 3, 5, 0);
        send_cmd("no_money", act_buy, 14, 13, 3, 1, 0);
        send_cmd("buyer_unchanged", act_check, 14, 14, 0, 0, 0);
        send_cmd("seller_unchanged", act_check, 15, 15, 0, 0, 0);
        send_cmd("deposit_ok", act_deposit, 14, 14, 0, 0, 1000);
        send_cmd("wallet_full", act_deposit, 13, 13, 0, 0, 1000);
        send_cmd("wallet_unchanged", act_check, 13, 13, 0, 0, 0);
        send_cmd("level_up", act_buy, 12, 13, 1, 7, 0);
        send_cmd("new_level_fee", act_buy, 12, 13, 3, 1, 0);
        send_cmd("after_level_up", act_check, 12, 12, 0, 0, 0);

        for (int n = 0; n < n_random; n++) begin
            b      = draw(16);
            s      = (b + 1 + draw(15)) % 16;
            pick   = draw(3);
            item   = draw(3) + 1;
            num    = draw(24) + 1;
            amount = draw(20000);
            if (pick == 0) begin
                send_cmd("random_buy", act_buy, b, s, item, num, 0);
            end else if (pick == 1) begin
                send_cmd("random_check", act_check, b, b, 0, 0, 0);
            end else begin
                send_cmd("random_deposit", act_deposit, b, b, 0, 0, amount);
            end
        end

        check_memory();
        report_and_stop();
    end

endmodule
